// ==== files.f ====
rtl/rv32i_types.sv
rtl/alu.sv
rtl/cmp.sv
rtl/phys_regfile.sv
rtl/rs_issue_ctrl.sv
rtl/fu_wrapper.sv
rtl/int_exec_top.sv
sim/int_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -f files.f --top-module int_exec_tb -o int_exec_sim
./obj_dir/int_exec_sim > sim.log 2>&1 || true
cat sim.log
grep -q "All tests passed" sim.log

// ==== sim/int_exec_tb.sv ====
module int_exec_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Kinds of micro-op in the table
    localparam int K_RR   = 0;
    localparam int K_LI   = 1;
    localparam int K_SLT  = 2;
    localparam int K_BR   = 3;
    localparam int K_JAL  = 4;
    localparam int K_JALR = 5;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    flush;
    logic                    dispatch;
    rv32i_types::fu_input_t  dispatch_op;
    logic                    full;
    rv32i_types::fu_output_t wb;

    rv32i_types::fu_input_t tbl[$];
    int                     bnd[$];
    rv32i_types::word_t     gold [64];
    rv32i_types::word_t     exp_val [64];
    rv32i_types::word_t     exp_pc [64];
    rv32i_types::word_t     exp_rs1 [64];
    rv32i_types::word_t     exp_rs2 [64];
    logic                   exp_taken [64];
    logic                   exp_wr [64];
    logic                   exp_pend [64];
    logic                   got [64] = '{default: 1'b0};
    int                     done_cyc [64];
    int                     sent = 0;
    int                     received = 0;
    int                     cycles = 0;
    int                     limit = 1000;

    int_exec_top DUT (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .dispatch    (dispatch),
        .dispatch_op (dispatch_op),
        .full        (full),
        .wb          (wb)
    );

    always #5 clk = ~clk;

    task automatic stop_run(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    function automatic rv32i_types::fu_input_t mk(int kind, logic [2:0] fn,
            rv32i_types::preg_t rs1, rv32i_types::preg_t rs2, rv32i_types::preg_t rd,
            rv32i_types::word_t imm, rv32i_types::word_t pc);
        rv32i_types::fu_input_t o;
        o = '0;
        o.valid = 1'b1;
        o.pc = pc;
        o.imm = imm;
        o.rs1 = rs1;
        o.rs2 = rs2;
        o.rd = rd;
        o.uses_rs1 = (kind == K_RR || kind == K_SLT || kind == K_BR || kind == K_JALR);
        o.uses_rs2 = (kind == K_RR || kind == K_SLT || kind == K_BR);
        o.opsel1 = (kind == K_LI) ? rv32i_types::OPSEL_IMM
                 : (kind == K_BR || kind == K_JAL) ? rv32i_types::OPSEL_PC
                 : rv32i_types::OPSEL_REG;
        o.opsel2 = (kind == K_LI) ? rv32i_types::OPSEL_ZERO
                 : (kind >= K_BR) ? rv32i_types::OPSEL_IMM : rv32i_types::OPSEL_REG;
        o.alu_op = (kind == K_RR) ? fn : rv32i_types::ALU_ADD;
        o.cmp_op = (kind == K_SLT || kind == K_BR) ? fn : rv32i_types::CMP_EQ;
        o.alu_en = (kind != K_SLT);
        o.is_branch = (kind == K_BR);
        o.is_jump = (kind == K_JAL);
        o.is_jumpr = (kind == K_JALR);
        // Branches keep a unique rd as their result id but write nothing
        o.writes_rd = (kind != K_BR);
        return o;
    endfunction

    function automatic rv32i_types::word_t alu_ref(logic [2:0] op, logic [31:0] a,
            logic [31:0] b);
        case (op)
            rv32i_types::ALU_ADD: return a + b;
            rv32i_types::ALU_SUB: return a - b;
            rv32i_types::ALU_AND: return a & b;
            rv32i_types::ALU_OR:  return a | b;
            rv32i_types::ALU_XOR: return a ^ b;
            rv32i_types::ALU_SLL: return a << b[4:0];
            rv32i_types::ALU_SRL: return a >> b[4:0];
            default:              return $unsigned($signed(a) >>> b[4:0]);
        endcase
    endfunction

    function automatic logic cmp_ref(logic [2:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            rv32i_types::CMP_EQ:  return a == b;
            rv32i_types::CMP_NE:  return a != b;
            rv32i_types::CMP_LT:  return $signed(a) < $signed(b);
            rv32i_types::CMP_GE:  return $signed(a) >= $signed(b);
            rv32i_types::CMP_LTU: return a < b;
            rv32i_types::CMP_GEU: return a >= b;
            default:              return 1'b0;
        endcase
    endfunction

    // Reference model, evaluated in table order at dispatch time
    task automatic record_expect(rv32i_types::fu_input_t o);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] f;
        logic        c;
        a = (o.opsel1 == rv32i_types::OPSEL_IMM) ? o.imm
          : (o.opsel1 == rv32i_types::OPSEL_PC) ? o.pc : gold[o.rs1];
        b = (o.opsel2 == rv32i_types::OPSEL_IMM) ? o.imm
          : (o.opsel2 == rv32i_types::OPSEL_ZERO) ? 32'd0 : gold[o.rs2];
        f = alu_ref(o.alu_op, a, b);
        c = o.is_branch ? cmp_ref(o.cmp_op, gold[o.rs1], gold[o.rs2]) : cmp_ref(o.cmp_op, a, b);
        exp_rs1[o.rd] = gold[o.rs1];
        exp_rs2[o.rd] = gold[o.rs2];
        exp_wr[o.rd] = o.writes_rd;
        exp_pc[o.rd] = o.pc + 32'd4;
        exp_taken[o.rd] = (o.is_jump || o.is_jumpr) ? 1'b1 : c;
        exp_val[o.rd] = o.alu_en ? f : {31'd0, c};
        if (o.is_branch) begin
            exp_val[o.rd] = 32'd0;
            exp_pc[o.rd] = c ? f : o.pc + 32'd4;
        end else if (o.is_jump || o.is_jumpr) begin
            exp_val[o.rd] = o.pc + 32'd4;
            exp_pc[o.rd] = o.is_jumpr ? {f[31:1], 1'b0} : f;
        end
        if (o.writes_rd && o.rd != 0) begin
            gold[o.rd] = exp_val[o.rd];
        end
        exp_pend[o.rd] = 1'b1;
        sent++;
    endtask

    task automatic run_batch(int first, int last);
        for (int i = first; i < last; i++) begin
            @(negedge clk);
            while (full) begin
                dispatch = 1'b0;
                @(negedge clk);
            end
            dispatch = 1'b1;
            dispatch_op = tbl[i];
            record_expect(tbl[i]);
        end
        @(negedge clk);
        dispatch = 1'b0;
        // Every result of the batch is due within a fixed budget per row
        for (int w = 0; w < 20 * (last - first) && sent != received; w++) begin
            @(negedge clk);
        end
        if (sent != received) begin
            stop_run("Missing result at the end of a batch");
        end
    endtask

    // Results are sampled at the rising edge, before the registers move
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            stop_run("Timeout: results did not arrive in time");
        end
        if (!rst && wb.valid) begin
            if (!exp_pend[wb.rd] || got[wb.rd]) begin
                stop_run($sformatf("Unexpected or duplicate result for tag %0d", wb.rd));
            end
            assert (wb.writes_rd == exp_wr[wb.rd]) else
                stop_run($sformatf("MISMATCH wb.writes_rd: got %h expected %h",
                    wb.writes_rd, exp_wr[wb.rd]));
            assert (wb.rd_value == exp_val[wb.rd]) else
                stop_run($sformatf("MISMATCH wb.rd_value: got %h expected %h",
                    wb.rd_value, exp_val[wb.rd]));
            assert (wb.pc_next == exp_pc[wb.rd]) else
                stop_run($sformatf("MISMATCH wb.pc_next: got %h expected %h",
                    wb.pc_next, exp_pc[wb.rd]));
            assert (wb.branch_taken == exp_taken[wb.rd]) else
                stop_run($sformatf("MISMATCH wb.branch_taken: got %h expected %h",
                    wb.branch_taken, exp_taken[wb.rd]));
            assert (wb.rs1_value == exp_rs1[wb.rd]) else
                stop_run($sformatf("MISMATCH wb.rs1_value: got %h expected %h",
                    wb.rs1_value, exp_rs1[wb.rd]));
            assert (wb.rs2_value == exp_rs2[wb.rd]) else
                stop_run($sformatf("MISMATCH wb.rs2_value: got %h expected %h",
                    wb.rs2_value, exp_rs2[wb.rd]));
            got[wb.rd] = 1'b1;
            done_cyc[wb.rd] = cycles;
            received++;
        end
    end

    initial begin
        void'($urandom(39865));
        rst = 1'b1;
        flush = 1'b0;
        dispatch = 1'b0;
        dispatch_op = '0;
        for (int i = 0; i < 64; i++) begin
            gold[i] = 32'd0;
            exp_pend[i] = 1'b0;
        end
        // Immediate loads, then every R-type operation on them
        for (int t = 1; t <= 3; t++) begin
            tbl.push_back(mk(K_LI, 0, 0, 0, rv32i_types::preg_t'(t), $urandom, 0));
        end
        for (int k = 0; k < 8; k++) begin
            tbl.push_back(mk(K_RR, rv32i_types::alu_op_t'(k), 1, 2,
                             rv32i_types::preg_t'(4 + k), 0, 0));
        end
        bnd.push_back(tbl.size());
        // Set-less-than on operands of opposite sign
        tbl.push_back(mk(K_LI, 0, 0, 0, 12, $urandom | 32'h8000_0000, 0));
        tbl.push_back(mk(K_LI, 0, 0, 0, 13, $urandom & 32'h7fff_ffff, 0));
        tbl.push_back(mk(K_SLT, rv32i_types::CMP_LT, 12, 13, 14, 0, 0));
        tbl.push_back(mk(K_SLT, rv32i_types::CMP_LTU, 12, 13, 15, 0, 0));
        tbl.push_back(mk(K_SLT, rv32i_types::CMP_LT, 13, 12, 16, 0, 0));
        tbl.push_back(mk(K_SLT, rv32i_types::CMP_LTU, 13, 12, 17, 0, 0));
        bnd.push_back(tbl.size());
        // Dependent chain with an independent load behind it
        tbl.push_back(mk(K_RR, rv32i_types::ALU_ADD, 1, 2, 20, 0, 0));
        tbl.push_back(mk(K_RR, rv32i_types::ALU_ADD, 20, 1, 21, 0, 0));
        tbl.push_back(mk(K_RR, rv32i_types::ALU_ADD, 21, 20, 22, 0, 0));
        tbl.push_back(mk(K_LI, 0, 0, 0, 23, $urandom, 0));
        bnd.push_back(tbl.size());
        // Branches and jumps
        tbl.push_back(mk(K_BR, rv32i_types::CMP_EQ, 1, 1, 30, $urandom & ~32'd1,
                         $urandom & ~32'd3));
        tbl.push_back(mk(K_BR, rv32i_types::CMP_NE, 1, 1, 31, $urandom & ~32'd1,
                         $urandom & ~32'd3));
        tbl.push_back(mk(K_BR, rv32i_types::CMP_LT, 12, 13, 32, 32'h40, 32'h1000));
        tbl.push_back(mk(K_BR, rv32i_types::CMP_GEU, 13, 12, 33, 32'h80, 32'h2000));
        tbl.push_back(mk(K_JAL, 0, 0, 0, 34, $urandom & ~32'd1, $urandom & ~32'd3));
        tbl.push_back(mk(K_JALR, 0, 3, 0, 35, $urandom | 32'd1, $urandom & ~32'd3));
        bnd.push_back(tbl.size());
        // Batch after the flush
        tbl.push_back(mk(K_RR, rv32i_types::ALU_XOR, 1, 2, 36, 0, 0));
        tbl.push_back(mk(K_RR, rv32i_types::ALU_SUB, 36, 3, 37, 0, 0));
        bnd.push_back(tbl.size());
        limit = 20 * (tbl.size() + 8) + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_batch(0, bnd[0]);
        run_batch(bnd[0], bnd[1]);
        run_batch(bnd[1], bnd[2]);
        assert (done_cyc[23] < done_cyc[22]) else
            stop_run("Independent micro-op did not finish before the chain tail");
        run_batch(bnd[2], bnd[3]);

        // Tag 50 waits on itself, so four micro-ops stay queued
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            dispatch = 1'b1;
            if (i == 4) begin
                assert (full) else
                    stop_run("Reservation station not full after four waiting micro-ops");
                // Ready load that must be dropped while full
                dispatch_op = mk(K_LI, 0, 0, 0, 54, $urandom, 0);
            end else begin
                dispatch_op = mk(K_RR, rv32i_types::ALU_ADD, 50, 50,
                                 rv32i_types::preg_t'(50 + i), 0, 0);
            end
        end
        @(negedge clk);
        dispatch = 1'b0;
        // A load taken in spite of full would finish in these cycles
        repeat (3) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        assert (!full) else
            stop_run("Reservation station still full after flush");

        // Second flush catches loads in the issue and writeback registers
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            dispatch = 1'b1;
            dispatch_op = mk(K_LI, 0, 0, 0, rv32i_types::preg_t'(56 + i), $urandom, 0);
        end
        @(negedge clk);
        dispatch = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (10) @(negedge clk);
        run_batch(bnd[3], bnd[4]);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== rtl/int_exec_top.sv ====
module int_exec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    dispatch,
    input  rv32i_types::fu_input_t  dispatch_op,
    output logic                    full,
    output rv32i_types::fu_output_t wb
);

    logic                              alloc;
    rv32i_types::preg_t                alloc_tag;
    logic [rv32i_types::NUM_PREGS-1:0] ready_mask;
    rv32i_types::fu_input_t            issue_op;
    rv32i_types::reg_read_t            reg_data;

    rs_issue_ctrl u_rs (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .dispatch    (dispatch),
        .dispatch_op (dispatch_op),
        .ready_mask  (ready_mask),
        .full        (full),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .issue_op    (issue_op)
    );

    // Read ports follow the issued micro-op
    phys_regfile u_prf (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .alloc_tag  (alloc_tag),
        .rs1        (issue_op.rs1),
        .rs2        (issue_op.rs2),
        .wb         (wb),
        .reg_data   (reg_data),
        .ready_mask (ready_mask)
    );

    fu_wrapper u_fu (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .issue_op (issue_op),
        .reg_data (reg_data),
        .wb       (wb)
    );

endmodule

// ==== rtl/fu_wrapper.sv ====
module fu_wrapper (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  rv32i_types::fu_input_t  issue_op,
    input  rv32i_types::reg_read_t  reg_data,
    output rv32i_types::fu_output_t wb
);

    rv32i_types::fu_input_t  op;
    rv32i_types::word_t      src1;
    rv32i_types::word_t      src2;
    rv32i_types::word_t      cmp_a;
    rv32i_types::word_t      cmp_b;
    rv32i_types::word_t      alu_f;
    rv32i_types::word_t      pc_plus4;
    logic                    cmp_br;
    rv32i_types::fu_output_t wb_d;
    rv32i_types::fu_output_t wb_q;

    assign op       = issue_op;
    assign pc_plus4 = op.pc + 32'd4;

    always_comb begin
        case (op.opsel1)
            rv32i_types::OPSEL_REG: src1 = reg_data.rs1_value;
            rv32i_types::OPSEL_IMM: src1 = op.imm;
            rv32i_types::OPSEL_PC:  src1 = op.pc;
            default:                src1 = '0;
        endcase
        case (op.opsel2)
            rv32i_types::OPSEL_REG:  src2 = reg_data.rs2_value;
            rv32i_types::OPSEL_IMM:  src2 = op.imm;
            rv32i_types::OPSEL_ZERO: src2 = '0;
            default:                 src2 = '0;
        endcase
    end

    // Branches compare the registers while the ALU forms the target
    always_comb begin
        if (op.is_branch) begin
            cmp_a = reg_data.rs1_value;
            cmp_b = reg_data.rs2_value;
        end else begin
            cmp_a = src1;
            cmp_b = src2;
        end
    end

    alu u_alu (
        .aluop (op.alu_op),
        .a     (src1),
        .b     (src2),
        .f     (alu_f)
    );

    cmp u_cmp (
        .cmpop (op.cmp_op),
        .a     (cmp_a),
        .b     (cmp_b),
        .br_en (cmp_br)
    );

    always_comb begin
        wb_d.valid        = op.valid;
        wb_d.writes_rd    = op.writes_rd;
        wb_d.rd           = op.rd;
        wb_d.rd_value     = alu_f;
        wb_d.pc_next      = pc_plus4;
        wb_d.branch_taken = cmp_br;
        wb_d.rs1_value    = reg_data.rs1_value;
        wb_d.rs2_value    = reg_data.rs2_value;
        if (op.is_branch) begin
            wb_d.writes_rd = 1'b0;
            wb_d.rd_value  = '0;
            if (cmp_br) begin
                wb_d.pc_next = alu_f;
            end
        end else if (op.is_jump) begin
            wb_d.rd_value     = pc_plus4;
            wb_d.pc_next      = alu_f;
            wb_d.branch_taken = 1'b1;
        end else if (op.is_jumpr) begin
            wb_d.rd_value     = pc_plus4;
            wb_d.pc_next      = {alu_f[31:1], 1'b0};
            wb_d.branch_taken = 1'b1;
        end else if (!op.alu_en) begin
            // Set-less-than style result
            wb_d.rd_value = {31'd0, cmp_br};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q <= wb_d;
        end
    end

    // The result already in the register is killed by a flush too
    always_comb begin
        wb = wb_q;
        if (flush) begin
            wb.valid = 1'b0;
        end
    end

endmodule

// ==== rtl/rs_issue_ctrl.sv ====
module rs_issue_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               flush,
    input  logic                               dispatch,
    input  rv32i_types::fu_input_t             dispatch_op,
    input  logic [rv32i_types::NUM_PREGS-1:0]  ready_mask,
    output logic                               full,
    output logic                               alloc,
    output rv32i_types::preg_t                 alloc_tag,
    output rv32i_types::fu_input_t             issue_op
);

    rv32i_types::fu_input_t           entry_op  [rv32i_types::RS_DEPTH];
    rv32i_types::rs_idx_t             entry_age [rv32i_types::RS_DEPTH];
    logic [rv32i_types::RS_DEPTH-1:0] entry_valid;
    logic [rv32i_types::RS_DEPTH-1:0] entry_rdy;
    logic [rv32i_types::RS_DEPTH-1:0] age_dec;

    logic                             issue_any;
    rv32i_types::rs_idx_t             issue_idx;
    rv32i_types::rs_idx_t             best_age;
    logic                             have_free;
    rv32i_types::rs_idx_t             disp_idx;
    logic                             accept;
    rv32i_types::fu_input_t           issue_q;

    // An entry is ready once every source it uses is marked ready
    always_comb begin
        for (int i = 0; i < rv32i_types::RS_DEPTH; i++) begin
            entry_rdy[i] = entry_valid[i]
                && (!entry_op[i].uses_rs1 || ready_mask[entry_op[i].rs1])
                && (!entry_op[i].uses_rs2 || ready_mask[entry_op[i].rs2]);
        end
    end

    // Age counts the younger valid entries, so the oldest has the largest age
    always_comb begin
        issue_any = 1'b0;
        issue_idx = '0;
        best_age  = '0;
        for (int i = 0; i < rv32i_types::RS_DEPTH; i++) begin
            if (entry_rdy[i] && (!issue_any || entry_age[i] > best_age)) begin
                issue_any = 1'b1;
                issue_idx = rv32i_types::rs_idx_t'(i);
                best_age  = entry_age[i];
            end
        end
    end

    // Lowest free slot, counting the one that issues this cycle
    always_comb begin
        have_free = 1'b0;
        disp_idx  = '0;
        for (int i = rv32i_types::RS_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i] || (issue_any && issue_idx == rv32i_types::rs_idx_t'(i))) begin
                have_free = 1'b1;
                disp_idx  = rv32i_types::rs_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rv32i_types::RS_DEPTH; i++) begin
            age_dec[i] = issue_any && (entry_age[i] > best_age);
        end
    end

    assign full      = !have_free;
    assign accept    = dispatch && have_free && !flush;
    assign alloc     = accept && dispatch_op.writes_rd;
    assign alloc_tag = dispatch_op.rd;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < rv32i_types::RS_DEPTH; i++) begin
                if (issue_any && issue_idx == rv32i_types::rs_idx_t'(i)) begin
                    entry_valid[i] <= 1'b0;
                end else if (entry_valid[i]) begin
                    entry_age[i] <= entry_age[i] + rv32i_types::rs_idx_t'(accept)
                                    - rv32i_types::rs_idx_t'(age_dec[i]);
                end
                if (accept && disp_idx == rv32i_types::rs_idx_t'(i)) begin
                    entry_valid[i] <= 1'b1;
                    entry_op[i]    <= dispatch_op;
                    entry_age[i]   <= '0;
                end
            end
        end
    end

    // Issue register feeding the functional unit and the read ports
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q       <= entry_op[issue_idx];
            issue_q.valid <= issue_any;
        end
    end

    assign issue_op = issue_q;

endmodule

// ==== rtl/phys_regfile.sv ====
module phys_regfile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc,
    input  rv32i_types::preg_t                 alloc_tag,
    input  rv32i_types::preg_t                 rs1,
    input  rv32i_types::preg_t                 rs2,
    input  rv32i_types::fu_output_t            wb,
    output rv32i_types::reg_read_t             reg_data,
    output logic [rv32i_types::NUM_PREGS-1:0]  ready_mask
);

    rv32i_types::word_t                regs [rv32i_types::NUM_PREGS];
    logic [rv32i_types::NUM_PREGS-1:0] ready;
    logic                              wr_en;
    logic                              alloc_en;

    // Tag 0 is the zero register and is never written or allocated
    assign wr_en    = wb.valid && wb.writes_rd && (wb.rd != '0);
    assign alloc_en = alloc && (alloc_tag != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv32i_types::NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (wr_en) begin
                regs[wb.rd] <= wb.rd_value;
                ready[wb.rd] <= 1'b1;
            end
            // A new allocation overrides a writeback to the same tag
            if (alloc_en) begin
                ready[alloc_tag] <= 1'b0;
            end
        end
    end

    // Plain combinational reads with no bypass of the write port
    assign reg_data.rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign reg_data.rs2_value = (rs2 == '0) ? '0 : regs[rs2];

    assign ready_mask = ready;

endmodule

// ==== rtl/cmp.sv ====
module cmp (
    input  rv32i_types::cmp_op_t cmpop,
    input  rv32i_types::word_t   a,
    input  rv32i_types::word_t   b,
    output logic                 br_en
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (cmpop)
            rv32i_types::CMP_EQ:  br_en = eq;
            rv32i_types::CMP_NE:  br_en = !eq;
            rv32i_types::CMP_LT:  br_en = lt_s;
            rv32i_types::CMP_GE:  br_en = !lt_s;
            rv32i_types::CMP_LTU: br_en = lt_u;
            rv32i_types::CMP_GEU: br_en = !lt_u;
            // Unused codes never hold
            default:              br_en = 1'b0;
        endcase
    end

endmodule

// ==== rtl/alu.sv ====
module alu (
    input  rv32i_types::alu_op_t aluop,
    input  rv32i_types::word_t   a,
    input  rv32i_types::word_t   b,
    output rv32i_types::word_t   f
);

    logic [4:0] shamt;

    // Only the low five bits of b count as shift amount
    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            rv32i_types::ALU_ADD: begin
                f = a + b;
            end
            rv32i_types::ALU_SUB: begin
                f = a - b;
            end
            rv32i_types::ALU_AND: begin
                f = a & b;
            end
            rv32i_types::ALU_OR: begin
                f = a | b;
            end
            rv32i_types::ALU_XOR: begin
                f = a ^ b;
            end
            rv32i_types::ALU_SLL: begin
                f = a << shamt;
            end
            rv32i_types::ALU_SRL: begin
                f = a >> shamt;
            end
            rv32i_types::ALU_SRA: begin
                f = rv32i_types::word_t'($signed(a) >>> shamt);
            end
            default: begin
                f = '0;
            end
        endcase
    end

endmodule

// ==== rtl/rv32i_types.sv ====
package rv32i_types;

    // Sizes of the execute cluster
    localparam int NUM_PREGS = 64;
    localparam int RS_DEPTH  = 4;
    localparam int RS_IDX_W  = $clog2(RS_DEPTH);

    typedef logic [31:0]         word_t;
    typedef logic [5:0]          preg_t;
    typedef logic [2:0]          alu_op_t;
    typedef logic [2:0]          cmp_op_t;
    typedef logic [1:0]          opsel_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    // ALU operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;
    localparam alu_op_t ALU_SRA = 3'd7;

    // Compare operations, following the RV32I branch funct3 values
    localparam cmp_op_t CMP_EQ  = 3'd0;
    localparam cmp_op_t CMP_NE  = 3'd1;
    localparam cmp_op_t CMP_LT  = 3'd4;
    localparam cmp_op_t CMP_GE  = 3'd5;
    localparam cmp_op_t CMP_LTU = 3'd6;
    localparam cmp_op_t CMP_GEU = 3'd7;

    // Operand sources; ZERO only for operand 2, PC only for operand 1
    localparam opsel_t OPSEL_REG  = 2'd0;
    localparam opsel_t OPSEL_IMM  = 2'd1;
    localparam opsel_t OPSEL_ZERO = 2'd2;
    localparam opsel_t OPSEL_PC   = 2'd3;

    // Decoded micro-op as held in the reservation station
    typedef struct packed {
        logic    valid;
        word_t   pc;
        word_t   imm;
        opsel_t  opsel1;
        opsel_t  opsel2;
        alu_op_t alu_op;
        cmp_op_t cmp_op;
        logic    alu_en;
        logic    is_branch;
        logic    is_jump;
        logic    is_jumpr;
        preg_t   rs1;
        preg_t   rs2;
        preg_t   rd;
        logic    uses_rs1;
        logic    uses_rs2;
        logic    writes_rd;
    } fu_input_t;

    typedef struct packed {
        word_t rs1_value;
        word_t rs2_value;
    } reg_read_t;

    // Writeback and branch result of the functional unit
    typedef struct packed {
        logic  valid;
        logic  writes_rd;
        preg_t rd;
        word_t rd_value;
        word_t pc_next;
        logic  branch_taken;
        word_t rs1_value;
        word_t rs2_value;
    } fu_output_t;

endpackage
